/* design/sbox_macros.svh */
`ifndef SBOX_MACROS_SVH
`define SBOX_MACROS_SVH

// ---------------------------------------------------------------------------
// Engine sizes
// ---------------------------------------------------------------------------
`define SBOX_LANES  4                        // Parallel S-box lanes
`define SBOX_SYM_W  6                        // One GF(2^6) symbol
`define SBOX_WORD_W (`SBOX_LANES * `SBOX_SYM_W) // Packed input and result word

// ---------------------------------------------------------------------------
// Register word addresses
// ---------------------------------------------------------------------------
`define SBOX_ADR_DIN    2'd0                 // Write-only input word
`define SBOX_ADR_DOUT   2'd1                 // Result, read clears done
`define SBOX_ADR_STATUS 2'd2                 // busy, done, overrun

`endif

/* design/gf_pkg.sv */
`default_nettype none

`include "sbox_macros.svh"

package gf_pkg;

  // -------------------------------------------------------------------------
  // Field elements
  // -------------------------------------------------------------------------

  // Subfield GF(2^3), polynomial basis over x^3+x^2+1
  typedef logic [`SBOX_SYM_W/2-1:0] gf8_t;

  // Full field GF(2^6), also the raw lane symbol
  typedef logic [`SBOX_SYM_W-1:0] gf64_t;

  // Four symbols side by side, lane 0 in the low bits
  typedef gf64_t [`SBOX_LANES-1:0] lane_word_t;

endpackage

`default_nettype wire

/* design/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  // -------------------------------------------------------------------------
  // Bus types
  // -------------------------------------------------------------------------
  typedef logic [1:0]  wb_adr_t;   // Word address
  typedef logic [31:0] wb_dat_t;   // Read and write data

  // Decoded register target of the current bus cycle
  typedef enum logic [1:0] {
    REG_DIN,
    REG_DOUT,
    REG_STATUS,
    REG_NONE
  } reg_sel_e;

  // -------------------------------------------------------------------------
  // Engine control
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE,                       // Nothing in flight, no result pending
    ST_RUN,                        // Word travelling through the lanes
    ST_HOLD                        // Result waiting for the host
  } eng_state_e;

endpackage

`default_nettype wire

/* design/gf64_power19.sv */
`default_nettype none

module gf64_power19 (
  input  gf_pkg::gf64_t sym,
  output gf_pkg::gf64_t sub
);

  import gf_pkg::*;

  // Rows of the basis change matrices, row 5 first
  localparam gf64_t [5:0] iso_rows = {
    6'b001100, 6'b100101, 6'b011001, 6'b101010, 6'b010011, 6'b110111
  };
  localparam gf64_t [5:0] inv_rows = {
    6'b011111, 6'b010001, 6'b000100, 6'b101111, 6'b011101, 6'b100111
  };

  localparam gf8_t gf8_x  = 3'b010;     // Subfield constant x
  localparam gf8_t gf8_x2 = 3'b100;     // Subfield constant x^2

  // -------------------------------------------------------------------------
  // Subfield and matrix helpers
  // -------------------------------------------------------------------------

  // Shift-and-add multiply, x^3 folds back to x^2+1
  function automatic gf8_t gf8_mul(gf8_t a, gf8_t b);
    gf8_t acc;
    gf8_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < 3; i++) begin
      if (b[i])
        acc ^= sh;
      sh = {sh[1:0], 1'b0} ^ (sh[2] ? 3'b101 : 3'b000);
    end
    return acc;
  endfunction

  // Each output bit is the parity of the input under one row mask
  function automatic gf64_t map6(gf64_t a, gf64_t [5:0] rows);
    gf64_t r;
    for (int i = 0; i < 6; i++)
      r[i] = ^(a & rows[i]);
    return r;
  endfunction

  // -------------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------------
  gf64_t z;                             // Symbol in composite basis
  gf8_t  x0, x1;                        // Low and high subfield halves
  gf8_t  x0_2, x1_2;
  gf8_t  x0_3, x1_3;
  gf8_t  x0_4, x1_4;
  gf8_t  y0, y1, y2, y3, y4, y5;        // Partial products of the power
  gf8_t  w_lo, w_hi;
  gf64_t w;
  gf64_t p;                             // Power back in the standard basis
  logic  fix;                           // Affine correction bit

  always_comb begin
    z  = map6(sym, iso_rows);
    x0 = z[2:0];
    x1 = z[5:3];

    x0_2 = gf8_mul(x0, x0);
    x1_2 = gf8_mul(x1, x1);
    x0_3 = gf8_mul(x0_2, x0);
    x1_3 = gf8_mul(x1_2, x1);
    x0_4 = gf8_mul(x0_2, x0_2);
    x1_4 = gf8_mul(x1_2, x1_2);

    y0 = gf8_mul(x0_4, x0);             // x0^5
    y1 = gf8_mul(x1_4, x1);             // x1^5
    y2 = gf8_mul(x0_4, x1);
    y3 = gf8_mul(x1_4, x0);
    y4 = gf8_mul(x0_3, x1_2);
    y5 = gf8_mul(x1_3, x0_2);

    // Constant weights of the composite field reduction
    w_lo = gf8_mul(y0 ^ y3, gf8_x2) ^ gf8_mul(y4, gf8_x);
    w_hi = gf8_mul(y1 ^ y2, gf8_x2) ^ gf8_mul(y5, gf8_x);
    w    = {w_hi, w_lo};

    p   = map6(w, inv_rows);
    fix = sym[2] ^ sym[4];
    sub = p ^ {6{fix}};
  end

endmodule

`default_nettype wire

/* design/sbox_lane.sv */
`default_nettype none

module sbox_lane (
  input  logic          clk,
  input  logic          rst_n,
  input  gf_pkg::gf64_t sym,
  input  logic          sym_vld,
  output gf_pkg::gf64_t res,
  output logic          res_vld
);

  import gf_pkg::*;

  gf64_t sym_q;                         // Stage 1 symbol
  logic  sym_q_vld;
  gf64_t sub;                           // Substituted stage 1 symbol

  // -------------------------------------------------------------------------
  // Stage 1
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n)
      sym_q_vld <= 1'b0;
    else
      sym_q_vld <= sym_vld;
  end

  always_ff @(posedge clk) begin
    if (sym_vld)
      sym_q <= sym;
  end

  gf64_power19 u_power19 (
    .sym (sym_q),
    .sub (sub)
  );

  // -------------------------------------------------------------------------
  // Stage 2
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n)
      res_vld <= 1'b0;
    else
      res_vld <= sym_q_vld;
  end

  always_ff @(posedge clk) begin
    if (sym_q_vld)
      res <= sub;
  end

endmodule

`default_nettype wire

/* design/sbox_dispatch.sv */
`default_nettype none

module sbox_dispatch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  gf_pkg::lane_word_t din_word,
  output gf_pkg::lane_word_t lane_sym,
  output logic               lane_vld
);

  // One pulse to every lane per accepted word
  always_ff @(posedge clk) begin
    if (!rst_n)
      lane_vld <= 1'b0;
    else
      lane_vld <= start;
  end

  // Held until the next start so later bus writes leave lanes alone
  always_ff @(posedge clk) begin
    if (start)
      lane_sym <= din_word;
  end

endmodule

`default_nettype wire

/* design/sbox_collect.sv */
`default_nettype none

`include "sbox_macros.svh"

module sbox_collect (
  input  logic                   clk,
  input  logic                   rst_n,
  input  gf_pkg::lane_word_t     res_word,
  input  logic [`SBOX_LANES-1:0] res_vld,
  input  logic                   done_clr,
  output gf_pkg::lane_word_t     result,
  output logic                   done
);

  logic all_vld;                        // Every lane has its symbol out

  assign all_vld = &res_vld;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
      done   <= 1'b0;
    end else if (all_vld) begin
      result <= res_word;
      done   <= 1'b1;                   // New result wins over a clear
    end else if (done_clr) begin
      done   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/wb_sbox_regs.sv */
`default_nettype none

`include "sbox_macros.svh"

module wb_sbox_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  wb_pkg::wb_adr_t    adr,
  input  wb_pkg::wb_dat_t    dat_w,
  output wb_pkg::wb_dat_t    dat_r,
  output logic               ack,
  output logic               start,
  output gf_pkg::lane_word_t din_word,
  input  gf_pkg::lane_word_t result,
  input  logic               done,
  output logic               done_clr
);

  import wb_pkg::*;

  reg_sel_e   reg_sel;
  eng_state_e state, state_nxt;
  logic       busy;
  logic       overrun;
  logic       wr_din, wr_status, rd_dout;

  // ---------------------------------------------------------------------------
  // Bus decode and acknowledge
  // ---------------------------------------------------------------------------
  always_comb begin
    reg_sel = REG_NONE;
    if (cyc && stb) begin
      case (adr)
        `SBOX_ADR_DIN:    reg_sel = REG_DIN;
        `SBOX_ADR_DOUT:   reg_sel = REG_DOUT;
        `SBOX_ADR_STATUS: reg_sel = REG_STATUS;
        default:          reg_sel = REG_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      ack <= 1'b0;
    else
      ack <= cyc & stb & ~ack;          // Single cycle, one clock after strobe
  end

  assign wr_din    = ack & we & (reg_sel == REG_DIN);
  assign wr_status = ack & we & (reg_sel == REG_STATUS);
  assign rd_dout   = ack & ~we & (reg_sel == REG_DOUT);

  assign busy     = (state == ST_RUN) & ~done;
  assign start    = wr_din & ~busy;
  assign done_clr = rd_dout | start;    // Stale done goes with a new word
  assign din_word = dat_w[`SBOX_WORD_W-1:0];

  always_comb begin
    dat_r = '0;
    case (reg_sel)
      REG_DOUT:   dat_r[`SBOX_WORD_W-1:0] = result;
      REG_STATUS: dat_r[2:0] = {overrun, done, busy};
      default:    dat_r = '0;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Engine control
  // ---------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start)
          state_nxt = ST_RUN;
      end
      ST_RUN: begin
        if (start)
          state_nxt = ST_RUN;
        else if (done && rd_dout)
          state_nxt = ST_IDLE;          // Result taken as it arrives
        else if (done)
          state_nxt = ST_HOLD;
      end
      ST_HOLD: begin
        if (start)
          state_nxt = ST_RUN;
        else if (rd_dout)
          state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      overrun <= 1'b0;
    else if (wr_din && busy)
      overrun <= 1'b1;                  // Dropped word
    else if (wr_status)
      overrun <= 1'b0;
  end

endmodule

`default_nettype wire

/* design/sbox_engine_top.sv */
`default_nettype none

`include "sbox_macros.svh"

module sbox_engine_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  wb_pkg::wb_adr_t adr,
  input  wb_pkg::wb_dat_t dat_w,
  output wb_pkg::wb_dat_t dat_r,
  output logic            ack
);

  import gf_pkg::*;

  logic                   start;
  lane_word_t             din_word;
  lane_word_t             lane_sym;       // Held input symbols
  logic                   lane_vld;
  lane_word_t             res_word;       // Lane outputs side by side
  logic [`SBOX_LANES-1:0] res_vld;
  lane_word_t             result;
  logic                   done;
  logic                   done_clr;

  wb_sbox_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .start    (start),
    .din_word (din_word),
    .result   (result),
    .done     (done),
    .done_clr (done_clr)
  );

  sbox_dispatch u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .din_word (din_word),
    .lane_sym (lane_sym),
    .lane_vld (lane_vld)
  );

  for (genvar g = 0; g < `SBOX_LANES; g++) begin : g_lane
    sbox_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .sym     (lane_sym[g]),
      .sym_vld (lane_vld),
      .res     (res_word[g]),
      .res_vld (res_vld[g])
    );
  end

  sbox_collect u_collect (
    .clk      (clk),
    .rst_n    (rst_n),
    .res_word (res_word),
    .res_vld  (res_vld),
    .done_clr (done_clr),
    .result   (result),
    .done     (done)
  );

endmodule

`default_nettype wire

/* bench/sbox_engine_properties.sv */
`default_nettype none

module sbox_engine_properties (
  input logic             clk,
  input logic             rst_n,
  input logic             cyc,
  input logic             stb,
  input logic             we,
  input logic             ack,
  input logic             busy,
  input logic             done,
  input wb_pkg::reg_sel_e reg_sel
);

  timeunit 1ns;
  timeprecision 100ps;

  import wb_pkg::*;

  // ---------------------------------------------------------------------------
  // Bus handshake
  // ---------------------------------------------------------------------------
  ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(cyc && stb))
    else $error("ack rose without cyc and stb");

  // ---------------------------------------------------------------------------
  // Engine timing
  // ---------------------------------------------------------------------------
  done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ack && we && reg_sel == REG_DIN && !busy |-> ##4 $rose(done))
    else $error("done not rising 4 cycles after an accepted word");

endmodule

bind wb_sbox_regs sbox_engine_properties u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .cyc     (cyc),
  .stb     (stb),
  .we      (we),
  .ack     (ack),
  .busy    (busy),
  .done    (done),
  .reg_sel (reg_sel)
);

`default_nettype wire

/* bench/sbox_engine_tb.sv */
`default_nettype none

`include "sbox_macros.svh"

module sbox_engine_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import gf_pkg::*;
  import wb_pkg::*;

  localparam int max_cycles = 4000;     // About 280 words at 8 cycles each, with margin

  // Basis change rows, index is the output bit
  localparam logic [5:0] iso_m [0:5] = '{
    6'b110111, 6'b010011, 6'b101010, 6'b011001, 6'b100101, 6'b001100
  };
  localparam logic [5:0] inv_m [0:5] = '{
    6'b100111, 6'b011101, 6'b101111, 6'b000100, 6'b010001, 6'b011111
  };
  localparam gf8_t ext_a     = 3'b101;  // x^3, linear term of y^2 = a*y + 1
  localparam gf8_t ext_scale = 3'b100;  // x^2 weight on the power

  logic    clk;
  logic    rst_n;
  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  logic    ack;

  int      n_checks;
  int      n_errors;
  int      cycles;
  string   test_name;

  sbox_engine_top u_sbox_engine_top (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic gf8_t gf8_times(input gf8_t a, input gf8_t b);
    logic [4:0] prod;
    prod = '0;
    for (int i = 0; i < 3; i++) begin
      if (b[i])
        prod = prod ^ ({2'b00, a} << i);
    end
    if (prod[4])
      prod = prod ^ 5'b10111;           // x^4 = x^2+x+1
    if (prod[3])
      prod = prod ^ 5'b01101;           // x^3 = x^2+1
    return prod[2:0];
  endfunction

  function automatic gf64_t basis_map(input gf64_t v, input logic inverse);
    gf64_t      out;
    logic [5:0] row;
    for (int i = 0; i < 6; i++) begin
      row    = inverse ? inv_m[i] : iso_m[i];
      out[i] = 1'b0;
      for (int j = 0; j < 6; j++)
        out[i] = out[i] ^ (v[j] & row[j]);
    end
    return out;
  endfunction

  // z^9 is the subfield norm of z, so z^19 = norm^2 * z
  function automatic gf64_t sbox_model(input gf64_t s);
    gf64_t z;
    gf64_t w;
    gf8_t  lo;
    gf8_t  hi;
    gf8_t  norm;
    gf8_t  scale;
    z     = basis_map(s, 1'b0);
    lo    = z[2:0];
    hi    = z[5:3];
    norm  = gf8_times(lo, lo) ^ gf8_times(ext_a, gf8_times(lo, hi)) ^ gf8_times(hi, hi);
    scale = gf8_times(ext_scale, gf8_times(norm, norm));
    w     = {gf8_times(scale, hi), gf8_times(scale, lo)};
    return basis_map(w, 1'b1) ^ {6{s[2] ^ s[4]}};
  endfunction

  function automatic lane_word_t word_model(input lane_word_t word);
    lane_word_t r;
    for (int l = 0; l < `SBOX_LANES; l++)
      r[l] = sbox_model(word[l]);
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // Bus and check tasks
  // ---------------------------------------------------------------------------
  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic wait_ack;
    @(negedge clk);
    while (!ack)
      @(negedge clk);
  endtask

  // Signals held through the ack cycle, dropped after its closing edge
  task automatic wb_write(input wb_adr_t a, input wb_dat_t d);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    wait_ack();
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t a, output wb_dat_t d);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    wait_ack();
    d = dat_r;
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic poll_done;
    wb_dat_t st;
    st = '0;
    while (!st[1])
      wb_read(`SBOX_ADR_STATUS, st);
  endtask

  task automatic run_word(input lane_word_t word);
    wb_dat_t    got;
    lane_word_t exp_w;
    exp_w = word_model(word);
    wb_write(`SBOX_ADR_DIN, {8'h00, word});
    poll_done();
    wb_read(`SBOX_ADR_DOUT, got);
    for (int l = 0; l < `SBOX_LANES; l++)
      check($sformatf("word %h lane %0d", word, l), {26'b0, exp_w[l]}, {26'b0, got[6*l +: 6]});
  endtask

  task automatic end_test(input int err0);
    $display("%s: %s, %0d errors", test_name, (n_errors == err0) ? "passed" : "failed",
             n_errors - err0);
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  task automatic reset_values;
    wb_dat_t got;
    int      err0;
    err0      = n_errors;
    test_name = "reset_values";
    wb_read(`SBOX_ADR_STATUS, got);
    check("status", 32'h0, got);
    wb_read(`SBOX_ADR_DOUT, got);
    check("dout", 32'h0, got);
    end_test(err0);
  endtask

  task automatic zero_word;
    wb_dat_t got;
    int      err0;
    err0      = n_errors;
    test_name = "zero_word";
    wb_write(`SBOX_ADR_DIN, 32'h0);
    wb_read(`SBOX_ADR_STATUS, got);     // Ends before done is due
    check("status while busy", 32'h1, got);
    poll_done();
    wb_read(`SBOX_ADR_STATUS, got);
    check("status with done", 32'h2, got);
    wb_read(`SBOX_ADR_DOUT, got);
    check("dout", 32'h0, got);
    wb_read(`SBOX_ADR_STATUS, got);
    check("status after read", 32'h0, got);
    end_test(err0);
  endtask

  // Rotation r moves every symbol through every lane position
  task automatic all_symbols;
    lane_word_t  w;
    logic [31:0] sym;
    int          err0;
    err0      = n_errors;
    test_name = "all_symbols";
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 16; i++) begin
        for (int l = 0; l < `SBOX_LANES; l++) begin
          sym  = 4 * i + (l + r) % 4;
          w[l] = sym[5:0];
        end
        run_word(w);
      end
    end
    end_test(err0);
  endtask

  task automatic random_words;
    logic [31:0] rnd;
    int          err0;
    err0      = n_errors;
    test_name = "random_words";
    for (int i = 0; i < 200; i++) begin
      rnd = $urandom();
      run_word(rnd[23:0]);
    end
    end_test(err0);
  endtask

  task automatic overrun_drop;
    lane_word_t first;
    lane_word_t second;
    wb_dat_t    got;
    int         err0;
    err0      = n_errors;
    test_name = "overrun_drop";
    first     = 24'h5a3c96;
    second    = 24'hc3a50f;
    wb_write(`SBOX_ADR_DIN, {8'h00, first});
    wb_write(`SBOX_ADR_DIN, {8'h00, second});   // Lanes still busy
    poll_done();
    wb_read(`SBOX_ADR_STATUS, got);
    check("status after drop", 32'h6, got);
    wb_read(`SBOX_ADR_DOUT, got);
    check("result of first word", {8'h00, word_model(first)}, got);
    wb_read(`SBOX_ADR_STATUS, got);
    check("status after read", 32'h4, got);
    wb_write(`SBOX_ADR_STATUS, 32'hffff_ffff);
    wb_read(`SBOX_ADR_STATUS, got);
    check("status after clear", 32'h0, got);
    end_test(err0);
  endtask

  task automatic back_to_back;
    lane_word_t words [0:5];
    wb_dat_t    got;
    int         err0;
    err0      = n_errors;
    test_name = "back_to_back";
    words     = '{24'hffffff, 24'h000001, 24'h123456, 24'hfedcba, 24'h820820, 24'h3f03f0};
    foreach (words[i])
      run_word(words[i]);
    wb_read(`SBOX_ADR_STATUS, got);
    check("final status", 32'h0, got);
    end_test(err0);
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    n_checks = 0;
    n_errors = 0;
    cycles   = 0;
    void'($urandom(32'hf8746423));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_values();
    zero_word();
    all_symbols();
    random_words();
    overrun_drop();
    back_to_back();

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/gf_pkg.sv
design/wb_pkg.sv
design/gf64_power19.sv
design/sbox_lane.sv
design/sbox_dispatch.sv
design/sbox_collect.sv
design/wb_sbox_regs.sv
design/sbox_engine_top.sv
bench/sbox_engine_properties.sv
bench/sbox_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
  --top-module sbox_engine_tb -Mdir obj_dir \
  && ./obj_dir/Vsbox_engine_tb | tee /dev/stderr | grep -q "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
